//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - design
    files:
      - design/mips_isa_pkg.sv
      - design/mips_ctrl_pkg.sv
      - design/mips_decode.sv
      - design/mips_alu.sv
      - design/mips_regfile.sv
      - design/mips_result.sv
      - design/mips_core.sv
      - target: test
        files:
          - bench/mips_core_tb.sv

//--- bench/mips_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module mips_core_tb;

  localparam int RESET_CYCLES = 2;
  localparam int TIMEOUT_MARGIN = 20;

  // MIPS32 encodings, ori and nor stand in for unsupported codes
  localparam logic [5:0] OPC_RTYPE = 6'd0;
  localparam logic [5:0] OPC_BEQ   = 6'd4;
  localparam logic [5:0] OPC_ADDI  = 6'd8;
  localparam logic [5:0] OPC_ORI   = 6'd13;
  localparam logic [5:0] OPC_LW    = 6'd35;
  localparam logic [5:0] OPC_SW    = 6'd43;
  localparam logic [5:0] FUNCT_ADD = 6'd32;
  localparam logic [5:0] FUNCT_SUB = 6'd34;
  localparam logic [5:0] FUNCT_AND = 6'd36;
  localparam logic [5:0] FUNCT_OR  = 6'd37;
  localparam logic [5:0] FUNCT_NOR = 6'd39;
  localparam logic [5:0] FUNCT_SLT = 6'd42;

  typedef struct packed {
    logic [`MIPS_XLEN-1:0] instr;
    logic [`MIPS_XLEN-1:0] rdata;
    logic [`MIPS_XLEN-1:0] pc;
    logic                  we;
    logic [`MIPS_XLEN-1:0] addr;
    logic [`MIPS_XLEN-1:0] wdata;
  } step_t;

  logic                  clk;
  logic                  reset;
  logic [`MIPS_XLEN-1:0] imem_addr;
  logic [`MIPS_XLEN-1:0] imem_data;
  logic [`MIPS_XLEN-1:0] dmem_addr;
  logic [`MIPS_XLEN-1:0] dmem_wdata;
  logic                  dmem_we;
  logic [`MIPS_XLEN-1:0] dmem_rdata;

  step_t steps[$];
  string names[$];
  int    errors;
  int    cycles;
  int    cycle_limit;

  mips_core mips_core_inst (
    .clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata)
  );

  always #4 clk = ~clk;

  // run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the program did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] funct);
    return {OPC_RTYPE, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] opc, input logic [4:0] rs,
                                         input logic [4:0] rt, input int imm);
    return {opc, rs, rt, imm[15:0]};
  endfunction

  task automatic add_step(input string name, input logic [31:0] instr,
                          input logic [31:0] rdata, input logic [31:0] pc, input logic we,
                          input logic [31:0] addr, input logic [31:0] wdata);
    step_t s;
    s = '{instr: instr, rdata: rdata, pc: pc, we: we, addr: addr, wdata: wdata};
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("error %s %s: expected %h, actual %h", name, what, expected, actual);
      errors++;
    end
  endtask

  // r1 = 5, r2 = -4, r3 = 0x100 as store base
  task automatic build_program();
    add_step("addi_r1", i_type(OPC_ADDI, 0, 1, 5), 0, 32'd0, 0, 0, 0);
    add_step("addi_r2_neg", i_type(OPC_ADDI, 0, 2, -4), 0, 32'd4, 0, 0, 0);
    add_step("addi_base", i_type(OPC_ADDI, 0, 3, 32'h100), 0, 32'd8, 0, 0, 0);
    add_step("add", r_type(1, 2, 4, FUNCT_ADD), 0, 32'd12, 0, 0, 0);
    add_step("sw_add", i_type(OPC_SW, 3, 4, 0), 0, 32'd16, 1, 32'h100, 32'd1);
    add_step("sub", r_type(1, 2, 5, FUNCT_SUB), 0, 32'd20, 0, 0, 0);
    add_step("sw_sub", i_type(OPC_SW, 3, 5, 4), 0, 32'd24, 1, 32'h104, 32'd9);
    add_step("and", r_type(1, 2, 6, FUNCT_AND), 0, 32'd28, 0, 0, 0);
    add_step("sw_and", i_type(OPC_SW, 3, 6, 8), 0, 32'd32, 1, 32'h108, 32'd4);
    add_step("or", r_type(1, 2, 7, FUNCT_OR), 0, 32'd36, 0, 0, 0);
    add_step("sw_or", i_type(OPC_SW, 3, 7, 12), 0, 32'd40, 1, 32'h10C, 32'hFFFF_FFFD);
    add_step("slt_neg", r_type(2, 1, 8, FUNCT_SLT), 0, 32'd44, 0, 0, 0);
    // negative store offset
    add_step("sw_slt", i_type(OPC_SW, 3, 8, -4), 0, 32'd48, 1, 32'hFC, 32'd1);
    add_step("lw", i_type(OPC_LW, 3, 9, 16), 32'hCAFE_F00D, 32'd52, 0, 0, 0);
    add_step("sw_lw", i_type(OPC_SW, 3, 9, 20), 0, 32'd56, 1, 32'h114, 32'hCAFE_F00D);
    add_step("addi_r0", i_type(OPC_ADDI, 0, 0, 7), 0, 32'd60, 0, 0, 0);
    add_step("sw_r0", i_type(OPC_SW, 3, 0, 24), 0, 32'd64, 1, 32'h118, 32'd0);
    // taken forward to 88, taken backward to 72, then not taken
    add_step("beq_fwd", i_type(OPC_BEQ, 1, 1, 4), 0, 32'd68, 0, 0, 0);
    add_step("beq_back", i_type(OPC_BEQ, 0, 0, -5), 0, 32'd88, 0, 0, 0);
    add_step("beq_ne", i_type(OPC_BEQ, 1, 2, 10), 0, 32'd72, 0, 0, 0);
    add_step("bad_opcode", i_type(OPC_ORI, 0, 1, 32'hFF), 0, 32'd76, 0, 0, 0);
    add_step("bad_funct", r_type(0, 0, 1, FUNCT_NOR), 0, 32'd80, 0, 0, 0);
    add_step("sw_r1_kept", i_type(OPC_SW, 3, 1, 28), 0, 32'd84, 1, 32'h11C, 32'd5);
  endtask

  initial begin
    int idx;
    clk = 1'b0;
    reset = 1'b1;
    // a store held on the bus through reset
    imem_data = i_type(OPC_SW, 0, 1, 0);
    dmem_rdata = '0;
    errors = 0;
    cycles = 0;
    build_program();
    cycle_limit = steps.size() + TIMEOUT_MARGIN;

    for (idx = 0; idx < RESET_CYCLES; idx++) begin
      @(negedge clk);
      check_value("reset", "dmem_we", 32'd0, {31'd0, dmem_we});
    end
    @(posedge clk);
    reset <= 1'b0;

    for (idx = 0; idx < steps.size(); idx++) begin
      imem_data <= steps[idx].instr;
      dmem_rdata <= steps[idx].rdata;
      @(negedge clk);
      check_value(names[idx], "imem_addr", steps[idx].pc, imem_addr);
      check_value(names[idx], "dmem_we", {31'd0, steps[idx].we}, {31'd0, dmem_we});
      if (steps[idx].we) begin
        check_value(names[idx], "dmem_addr", steps[idx].addr, dmem_addr);
        check_value(names[idx], "dmem_wdata", steps[idx].wdata, dmem_wdata);
      end
      @(posedge clk);
    end

    $display("%0d steps run, %0d errors", steps.size(), errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module mips_alu (
  input  logic [`MIPS_XLEN-1:0] a,
  input  logic [`MIPS_XLEN-1:0] rt_data,
  input  logic [`MIPS_XLEN-1:0] imm,
  input  mips_ctrl_pkg::ctrl_t  ctrl,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  zero
);

  import mips_ctrl_pkg::*;

  logic [`MIPS_XLEN-1:0] b;

  assign b = ctrl.alu_src ? imm : rt_data;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      // signed compare
      ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      default: result = '0;
    endcase
  end

  // used by beq
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- design/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// data and address width
`define MIPS_XLEN 32

// architectural register count
`define MIPS_REG_COUNT 32

// first fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

//--- design/mips_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module mips_core (
  input  logic                  clk,
  input  logic                  reset,
  output logic [`MIPS_XLEN-1:0] imem_addr,
  input  logic [`MIPS_XLEN-1:0] imem_data,
  output logic [`MIPS_XLEN-1:0] dmem_addr,
  output logic [`MIPS_XLEN-1:0] dmem_wdata,
  output logic                  dmem_we,
  input  logic [`MIPS_XLEN-1:0] dmem_rdata
);

  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] pc_next;
  instr_fields_t         fields;
  ctrl_t                 ctrl;
  logic [`MIPS_XLEN-1:0] rs_data;
  logic [`MIPS_XLEN-1:0] rt_data;
  logic [`MIPS_XLEN-1:0] alu_result;
  logic                  zero;
  logic [`MIPS_XLEN-1:0] wb_data;
  reg_idx_t              wb_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign imem_addr = pc;

  mips_decode decode_inst (.instr(imem_data), .fields(fields), .ctrl(ctrl));

  // register write held off while in reset
  mips_regfile regfile_inst (
    .clk(clk), .reset(reset), .rs(fields.rs), .rt(fields.rt),
    .rs_data(rs_data), .rt_data(rt_data),
    .we(ctrl.reg_write && !reset), .wr_idx(wb_idx), .wr_data(wb_data)
  );

  mips_alu alu_inst (
    .a(rs_data), .rt_data(rt_data), .imm(fields.imm), .ctrl(ctrl),
    .result(alu_result), .zero(zero)
  );

  mips_result result_inst (
    .pc(pc), .fields(fields), .ctrl(ctrl), .alu_result(alu_result), .zero(zero),
    .mem_data(dmem_rdata), .wb_data(wb_data), .wb_idx(wb_idx), .pc_next(pc_next)
  );

  // data port
  assign dmem_addr = alu_result;
  assign dmem_wdata = rt_data;
  assign dmem_we = ctrl.mem_write && !reset;

  // sequential fetch whenever no branch is decoded
  assert property (@(posedge clk) disable iff (reset)
    !ctrl.branch |=> imem_addr == $past(imem_addr) + `MIPS_XLEN'(4));

endmodule

`default_nettype wire

//--- design/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  // one control word per instruction
  typedef struct packed {
    logic    reg_write;
    // rd instead of rt as destination
    logic    reg_dst;
    // immediate instead of rt data as operand b
    logic    alu_src;
    logic    mem_write;
    logic    mem_to_reg;
    logic    branch;
    alu_op_e alu_op;
  } ctrl_t;

endpackage

`default_nettype wire

//--- design/mips_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module mips_decode (
  input  logic [`MIPS_XLEN-1:0]      instr,
  output mips_isa_pkg::instr_fields_t fields,
  output mips_ctrl_pkg::ctrl_t        ctrl
);

  import mips_isa_pkg::*;
  import mips_ctrl_pkg::*;

  // field split, fixed 32-bit encoding
  assign fields.opcode = instr[31:26];
  assign fields.rs     = instr[25:21];
  assign fields.rt     = instr[20:16];
  assign fields.rd     = instr[15:11];
  assign fields.funct  = instr[5:0];
  assign fields.imm    = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};

  always_comb begin
    // unsupported codes fall through as a no-op
    ctrl = '{default: '0, alu_op: ALU_ADD};
    case (fields.opcode)
      OP_RTYPE: begin
        ctrl.reg_dst = 1'b1;
        ctrl.reg_write = 1'b1;
        case (fields.funct)
          FN_ADD:  ctrl.alu_op = ALU_ADD;
          FN_SUB:  ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_ADDI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
      end
      OP_LW: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      OP_BEQ: begin
        // compare by subtraction, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;
      end
      default: ;
    endcase
  end

  // a store never writes back
  assert final (!(ctrl.reg_write && ctrl.mem_write));

endmodule

`default_nettype wire

//--- design/mips_isa_pkg.sv
`default_nettype none

`include "mips_config.svh"

package mips_isa_pkg;

  // primary opcodes kept from the base ISA
  typedef enum logic [5:0] {
    OP_RTYPE = 6'd0,
    OP_BEQ   = 6'd4,
    OP_ADDI  = 6'd8,
    OP_LW    = 6'd35,
    OP_SW    = 6'd43
  } opcode_e;

  // R-type function codes
  typedef enum logic [5:0] {
    FN_ADD = 6'd32,
    FN_SUB = 6'd34,
    FN_AND = 6'd36,
    FN_OR  = 6'd37,
    FN_SLT = 6'd42
  } funct_e;

  typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] reg_idx_t;

  // raw opcode/funct bits, unsupported codes pass through unchanged
  typedef struct packed {
    logic [5:0]            opcode;
    reg_idx_t              rs;
    reg_idx_t              rt;
    reg_idx_t              rd;
    logic [5:0]            funct;
    logic [`MIPS_XLEN-1:0] imm;
  } instr_fields_t;

endpackage

`default_nettype wire

//--- design/mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module mips_regfile (
  input  logic                   clk,
  input  logic                   reset,
  input  mips_isa_pkg::reg_idx_t rs,
  input  mips_isa_pkg::reg_idx_t rt,
  output logic [`MIPS_XLEN-1:0]  rs_data,
  output logic [`MIPS_XLEN-1:0]  rt_data,
  input  logic                   we,
  input  mips_isa_pkg::reg_idx_t wr_idx,
  input  logic [`MIPS_XLEN-1:0]  wr_data
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (we && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // combinational reads, r0 forced to zero
  assign rs_data = (rs == '0) ? '0 : regs[rs];
  assign rt_data = (rt == '0) ? '0 : regs[rt];

  // r0 storage stays clear whatever the core writes
  assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

//--- design/mips_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_config.svh"

module mips_result (
  input  logic [`MIPS_XLEN-1:0]       pc,
  input  mips_isa_pkg::instr_fields_t fields,
  input  mips_ctrl_pkg::ctrl_t        ctrl,
  input  logic [`MIPS_XLEN-1:0]       alu_result,
  input  logic                        zero,
  input  logic [`MIPS_XLEN-1:0]       mem_data,
  output logic [`MIPS_XLEN-1:0]       wb_data,
  output mips_isa_pkg::reg_idx_t      wb_idx,
  output logic [`MIPS_XLEN-1:0]       pc_next
);

  logic [`MIPS_XLEN-1:0] pc_plus4;
  logic [`MIPS_XLEN-1:0] branch_target;

  // write-back source and destination
  assign wb_data = ctrl.mem_to_reg ? mem_data : alu_result;
  assign wb_idx = ctrl.reg_dst ? fields.rd : fields.rt;

  assign pc_plus4 = pc + `MIPS_XLEN'(4);
  // word offset relative to the following instruction
  assign branch_target = pc_plus4 + {fields.imm[`MIPS_XLEN-3:0], 2'b00};

  assign pc_next = (ctrl.branch && zero) ? branch_target : pc_plus4;

  // pc comes from the core register, undefined before the first reset
  assert final ($isunknown(pc) || pc_next[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/mips_isa_pkg.sv
design/mips_ctrl_pkg.sv
design/mips_decode.sv
design/mips_alu.sv
design/mips_regfile.sv
design/mips_result.sv
design/mips_core.sv
bench/mips_core_tb.sv
